// File: hw/fabric_defs.svh
`ifndef FABRIC_DEFS_SVH
`define FABRIC_DEFS_SVH

// bus masters, one AXI4-Lite port each
`define NO_MASTERS 3

// register banks on the shared bus
`define NO_SLAVES 5

// words per bank
`define REGS_PER_SLAVE 16

// data path width, byte strobes follow from it
`define DATA_W 32

`endif

// File: hw/axi_lite_pkg.sv
package axi_lite_pkg;

`include "fabric_defs.svh"

    // only the two codes this fabric can produce
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        DECERR = 2'b11
    } axi_resp_e;

    // master side of all five channels
    typedef struct packed {
        logic                  aw_valid;
        logic [31:0]           aw_addr;
        logic                  w_valid;
        logic [`DATA_W-1:0]    w_data;
        logic [`DATA_W/8-1:0]  w_strb;
        logic                  b_ready;
        logic                  ar_valid;
        logic [31:0]           ar_addr;
        logic                  r_ready;
    } axi_lite_req_t;

    // slave side, driven by the port
    typedef struct packed {
        logic                  aw_ready;
        logic                  w_ready;
        logic                  b_valid;
        axi_resp_e             b_resp;
        logic                  ar_ready;
        logic                  r_valid;
        logic [`DATA_W-1:0]    r_data;
        axi_resp_e             r_resp;
    } axi_lite_rsp_t;

endpackage

// File: hw/fabric_pkg.sv
package fabric_pkg;

`include "fabric_defs.svh"

    // index of a bus master
    typedef logic [$clog2(`NO_MASTERS)-1:0] master_id_t;

    // target bank id, zero means no request
    typedef logic [$clog2(`NO_SLAVES+1)-1:0] slave_id_t;

    // word index inside one bank
    typedef logic [$clog2(`REGS_PER_SLAVE)-1:0] reg_idx_t;

    // one address word, seen raw or split into fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [20:0] upper;
            logic [2:0]  region;
            logic [1:0]  unused;
            reg_idx_t    reg_idx;
            logic [1:0]  byte_off;
        } f;
    } fabric_addr_u;

    // command on the shared bus
    typedef struct packed {
        logic                  write;
        reg_idx_t              reg_idx;
        logic [`DATA_W-1:0]    wdata;
        logic [`DATA_W/8-1:0]  wstrb;
    } bus_cmd_t;

    // bank answer, done is a one-cycle pulse
    typedef struct packed {
        logic                  done;
        logic [`DATA_W-1:0]    rdata;
    } bus_rsp_t;

    typedef enum logic [1:0] {
        SEL_IDLE    = 2'b00,
        SEL_SPREAD  = 2'b01,
        SEL_PREEMPT = 2'b10
    } sel_mode_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_GRANT,
        ARB_ACCESS
    } arb_state_e;

endpackage

// File: hw/master_port.sv
`timescale 1ns/10ps

`include "fabric_defs.svh"

module master_port
    import axi_lite_pkg::*;
    import fabric_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  axi_lite_req_t axi_req,
    output axi_lite_rsp_t axi_rsp,
    output slave_id_t     bus_req,
    output bus_cmd_t      cmd,
    input  bus_rsp_t      bus_rsp,
    input  logic          done
);

    // accept, wait for the bus, respond
    typedef enum logic [1:0] {
        MP_IDLE,
        MP_WAIT,
        MP_RESP
    } mp_state_e;

    mp_state_e            state;
    logic                 wr_accept;
    logic                 rd_accept;
    logic                 rsp_taken;
    fabric_addr_u         in_addr;
    logic                 in_decerr;
    slave_id_t            in_slave;

    // captured transaction
    logic                 write_q;
    slave_id_t            slave_q;
    reg_idx_t             reg_q;
    logic [`DATA_W-1:0]   wdata_q;
    logic [`DATA_W/8-1:0] wstrb_q;
    axi_resp_e            resp_q;
    logic [`DATA_W-1:0]   rdata_q;

    // write needs both address and data at once
    assign wr_accept = (state == MP_IDLE) && axi_req.aw_valid && axi_req.w_valid;
    // reads only when no write is waiting
    assign rd_accept = (state == MP_IDLE) && axi_req.ar_valid &&
                       !(axi_req.aw_valid && axi_req.w_valid);

    // decode the address that is about to be captured
    always_comb begin
        in_addr.raw = wr_accept ? axi_req.aw_addr : axi_req.ar_addr;
        in_decerr   = (in_addr.f.upper != '0) || (in_addr.f.region >= 3'(`NO_SLAVES));
        in_slave    = in_decerr ? '0 : in_addr.f.region + 3'd1;
    end

    assign rsp_taken = (axi_rsp.b_valid && axi_req.b_ready) ||
                       (axi_rsp.r_valid && axi_req.r_ready);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= MP_IDLE;
        end else begin
            case (state)
                // unmapped goes straight to the response
                MP_IDLE: if (wr_accept || rd_accept) state <= in_decerr ? MP_RESP : MP_WAIT;
                MP_WAIT: if (done) state <= MP_RESP;
                MP_RESP: if (rsp_taken) state <= MP_IDLE;
                default: state <= MP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept || rd_accept) begin
            write_q <= wr_accept;
            slave_q <= in_slave;
            reg_q   <= in_addr.f.reg_idx;
            wdata_q <= axi_req.w_data;
            // reads carry no strobes onto the bus
            wstrb_q <= wr_accept ? axi_req.w_strb : '0;
            resp_q  <= in_decerr ? DECERR : OKAY;
            rdata_q <= '0;
        end else if ((state == MP_WAIT) && done && !write_q) begin
            rdata_q <= bus_rsp.rdata;
        end
    end

    // request only while waiting for the bus
    assign bus_req = (state == MP_WAIT) ? slave_q : '0;

    always_comb begin
        cmd.write   = write_q;
        cmd.reg_idx = reg_q;
        cmd.wdata   = wdata_q;
        cmd.wstrb   = wstrb_q;
    end

    always_comb begin
        axi_rsp          = '0;
        axi_rsp.aw_ready = wr_accept;
        axi_rsp.w_ready  = wr_accept;
        axi_rsp.ar_ready = rd_accept;
        // response held until the master takes it
        axi_rsp.b_valid  = (state == MP_RESP) && write_q;
        axi_rsp.b_resp   = resp_q;
        axi_rsp.r_valid  = (state == MP_RESP) && !write_q;
        axi_rsp.r_data   = rdata_q;
        axi_rsp.r_resp   = resp_q;
    end

endmodule

// File: hw/priority_selector.sv
`timescale 1ns/10ps

`include "fabric_defs.svh"

module priority_selector
    import fabric_pkg::*;
(
    input  sel_mode_e  mode,
    input  master_id_t master_in,
    input  slave_id_t  slave_in,
    input  slave_id_t  slave_id [`NO_MASTERS-1:0],
    output master_id_t master_out,
    output slave_id_t  slave_out,
    output logic       request
);

    // which masters may win in the current mode
    logic [`NO_MASTERS-1:0] eligible;

    // any master asking at all
    always_comb begin
        request = 1'b0;
        for (int i = 0; i < `NO_MASTERS; i++) begin
            if (slave_id[i] != '0) begin
                request = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `NO_MASTERS; i++) begin
            unique case (mode)
                SEL_IDLE:    eligible[i] = (slave_id[i] != '0);
                // skip masters aiming at the bank just served
                SEL_SPREAD:  eligible[i] = (slave_id[i] != '0) && (slave_id[i] != slave_in);
                // only a higher priority master may take over
                SEL_PREEMPT: eligible[i] = (slave_id[i] != '0) &&
                                           (master_id_t'(i) < master_in);
                default:     eligible[i] = 1'b0;
            endcase
        end
    end

    // no match keeps the inputs
    always_comb begin
        master_out = master_in;
        slave_out  = slave_in;
        // walk downwards, lowest eligible index is written last
        for (int i = `NO_MASTERS - 1; i >= 0; i--) begin
            if (eligible[i]) begin
                master_out = master_id_t'(i);
                slave_out  = slave_id[i];
            end
        end
    end

endmodule

// File: hw/bus_arbiter.sv
`timescale 1ns/10ps

`include "fabric_defs.svh"

module bus_arbiter
    import fabric_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  slave_id_t              bus_req [`NO_MASTERS-1:0],
    input  bus_cmd_t               cmd_in [`NO_MASTERS-1:0],
    output logic [`NO_SLAVES-1:0]  bank_sel,
    output bus_cmd_t               bus_cmd,
    input  bus_rsp_t               bank_rsp [`NO_SLAVES-1:0],
    output bus_rsp_t               port_rsp,
    output logic [`NO_MASTERS-1:0] done
);

    arb_state_e state;
    master_id_t cur_master;
    slave_id_t  cur_slave;
    logic       spread_q;

    sel_mode_e  sel_mode;
    master_id_t sel_master;
    slave_id_t  sel_slave;
    logic       sel_request;
    logic       idle_win;

    // grant checks for preemption, idle spreads after each access
    always_comb begin
        if (state == ARB_GRANT) begin
            sel_mode = SEL_PREEMPT;
        end else if (spread_q) begin
            sel_mode = SEL_SPREAD;
        end else begin
            sel_mode = SEL_IDLE;
        end
    end

    priority_selector priority_selector_i (
        .mode       (sel_mode),
        .master_in  (cur_master),
        .slave_in   (cur_slave),
        .slave_id   (bus_req),
        .master_out (sel_master),
        .slave_out  (sel_slave),
        .request    (sel_request)
    );

    // in spread mode a miss hands back cur_slave unchanged
    assign idle_win = sel_request && (!spread_q || (sel_slave != cur_slave));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ARB_IDLE;
            cur_master <= '0;
            cur_slave  <= '0;
            spread_q   <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (idle_win) begin
                        state      <= ARB_GRANT;
                        cur_master <= sel_master;
                        cur_slave  <= sel_slave;
                    end else if (spread_q) begin
                        // everyone wants the same bank, fall back to idle pick
                        spread_q <= 1'b0;
                    end
                end
                ARB_GRANT: begin
                    if (sel_master != cur_master) begin
                        // lower index arrived, grant again
                        cur_master <= sel_master;
                        cur_slave  <= sel_slave;
                    end else begin
                        state <= ARB_ACCESS;
                    end
                end
                ARB_ACCESS: begin
                    state    <= ARB_IDLE;
                    spread_q <= 1'b1;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // granted port drives the bus
    always_comb begin
        bus_cmd = cmd_in[0];
        for (int m = 0; m < `NO_MASTERS; m++) begin
            if (cur_master == master_id_t'(m)) bus_cmd = cmd_in[m];
        end
    end

    // one-hot select, access cycle only
    always_comb begin
        bank_sel = '0;
        for (int s = 0; s < `NO_SLAVES; s++) begin
            bank_sel[s] = (state == ARB_ACCESS) && (cur_slave == slave_id_t'(s + 1));
        end
    end

    // answer of the bank last accessed
    always_comb begin
        port_rsp = '0;
        for (int s = 0; s < `NO_SLAVES; s++) begin
            if (cur_slave == slave_id_t'(s + 1)) port_rsp = bank_rsp[s];
        end
    end

    always_comb begin
        for (int m = 0; m < `NO_MASTERS; m++) begin
            done[m] = port_rsp.done && (cur_master == master_id_t'(m));
        end
    end

endmodule

// File: hw/slave_bank.sv
`timescale 1ns/10ps

`include "fabric_defs.svh"

module slave_bank
    import fabric_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     sel,
    input  bus_cmd_t cmd,
    output bus_rsp_t rsp
);

    // register file of the bank
    logic [`DATA_W-1:0] regs [`REGS_PER_SLAVE];

    // registered answer
    logic               done_q;
    logic [`DATA_W-1:0] rdata_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < `REGS_PER_SLAVE; r++) begin
                regs[r] <= '0;
            end
        end else if (sel && cmd.write) begin
            // merge only the strobed bytes
            for (int b = 0; b < `DATA_W / 8; b++) begin
                if (cmd.wstrb[b]) begin
                    regs[cmd.reg_idx][8*b +: 8] <= cmd.wdata[8*b +: 8];
                end
            end
        end
    end

    // done one cycle after select
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= sel;
        end
    end

    // old contents on a write, nobody reads them then
    always_ff @(posedge clk) begin
        if (sel) begin
            rdata_q <= regs[cmd.reg_idx];
        end
    end

    always_comb begin
        rsp.done  = done_q;
        rsp.rdata = rdata_q;
    end

endmodule

// File: hw/bus_fabric_top.sv
`timescale 1ns/10ps

`include "fabric_defs.svh"

module bus_fabric_top
    import axi_lite_pkg::*;
    import fabric_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  axi_lite_req_t m_req [`NO_MASTERS-1:0],
    output axi_lite_rsp_t m_rsp [`NO_MASTERS-1:0]
);

    // port side of the arbiter
    slave_id_t              bus_req  [`NO_MASTERS-1:0];
    bus_cmd_t               port_cmd [`NO_MASTERS-1:0];
    bus_rsp_t               port_rsp;
    logic [`NO_MASTERS-1:0] done;

    // bank side of the arbiter
    bus_cmd_t               bus_cmd;
    logic [`NO_SLAVES-1:0]  bank_sel;
    bus_rsp_t               bank_rsp [`NO_SLAVES-1:0];

    for (genvar m = 0; m < `NO_MASTERS; m++) begin : g_port
        master_port master_port_i (
            .clk     (clk),
            .arst_n  (arst_n),
            .axi_req (m_req[m]),
            .axi_rsp (m_rsp[m]),
            .bus_req (bus_req[m]),
            .cmd     (port_cmd[m]),
            // response is shared, done picks the port
            .bus_rsp (port_rsp),
            .done    (done[m])
        );
    end

    bus_arbiter bus_arbiter_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .bus_req  (bus_req),
        .cmd_in   (port_cmd),
        .bank_sel (bank_sel),
        .bus_cmd  (bus_cmd),
        .bank_rsp (bank_rsp),
        .port_rsp (port_rsp),
        .done     (done)
    );

    for (genvar s = 0; s < `NO_SLAVES; s++) begin : g_bank
        slave_bank slave_bank_i (
            .clk    (clk),
            .arst_n (arst_n),
            .sel    (bank_sel[s]),
            .cmd    (bus_cmd),
            .rsp    (bank_rsp[s])
        );
    end

endmodule

// File: sim/fabric_checker.sv
`timescale 1ns/10ps

`include "fabric_defs.svh"

module fabric_checker
    import fabric_pkg::*;
(
    input logic                   clk,
    input logic                   arst_n,
    input arb_state_e             state,
    input master_id_t             cur_master,
    input slave_id_t              bus_req [`NO_MASTERS-1:0],
    input logic [`NO_SLAVES-1:0]  bank_sel,
    input logic [`NO_MASTERS-1:0] done
);

    // at most one port hears done
    a_done_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(done))
        else $error("done raised for more than one port");

    // one bank at a time, access cycle only
    a_sel_access: assert property (@(posedge clk) disable iff (!arst_n)
        (bank_sel != '0) |-> ($onehot(bank_sel) && (state == ARB_ACCESS)))
        else $error("bank select not one-hot or outside access");

    // granted port keeps asking until its bank answers
    a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        ((state == ARB_GRANT) || (state == ARB_ACCESS)) |-> (bus_req[cur_master] != '0))
        else $error("granted master dropped its request");

    a_done_follows: assert property (@(posedge clk) disable iff (!arst_n)
        (state == ARB_ACCESS) |=> (done != '0))
        else $error("no done one cycle after access");

    // and never done without an access just before
    a_done_source: assert property (@(posedge clk) disable iff (!arst_n)
        (done != '0) |-> ($past(state) == ARB_ACCESS))
        else $error("done without a preceding access");

endmodule

bind bus_arbiter fabric_checker fabric_checker_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .state      (state),
    .cur_master (cur_master),
    .bus_req    (bus_req),
    .bank_sel   (bank_sel),
    .done       (done)
);

// File: sim/tb_bus_fabric.sv
`timescale 1ns/10ps

`include "fabric_defs.svh"

module tb_bus_fabric
    import axi_lite_pkg::*;
();

    // cycles any single wait may take
    localparam int TIMEOUT = 200;

    logic          clk;
    logic          arst_n;
    axi_lite_req_t m_req [`NO_MASTERS-1:0];
    axi_lite_rsp_t m_rsp [`NO_MASTERS-1:0];

    // expected contents of every bank
    logic [31:0] model [`NO_SLAVES][`REGS_PER_SLAVE];
    logic [31:0] lfsr = 32'h8605;
    int          err_count = 0;
    int          test_errs = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    // race setup, a start of -1 keeps that master out
    int race_bank [`NO_MASTERS];
    int race_start [`NO_MASTERS];
    int order_q [$];

    bus_fabric_top bus_fabric_top_i (
        .clk    (clk),
        .arst_n (arst_n),
        .m_req  (m_req),
        .m_rsp  (m_rsp)
    );

    always #5 clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // region in bits 10:8, word index in bits 5:2
    function automatic logic [31:0] make_addr(input int bank, input int reg_i);
        return (32'(bank) << 8) | (32'(reg_i) << 2);
    endfunction

    // byte lanes under strb take the new data
    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                          input logic [3:0] strb);
        logic [31:0] v;
        v = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) v[8*b +: 8] = data[8*b +: 8];
        end
        return v;
    endfunction

    function automatic void check_equal(input string name, input logic [31:0] exp,
                                        input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %0s: expected %h, actual %h", name, exp, act);
            err_count++;
        end
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // wait for b or r valid, hold ready back for dly cycles, then take it
    task automatic take_rsp(input int m, input bit wr, input int dly,
                            output logic [1:0] resp, output logic [31:0] rdata);
        bit hit;
        hit = 1'b0;
        for (int n = 0; n < TIMEOUT && !hit; n++) begin
            @(negedge clk);
            hit = wr ? m_rsp[m].b_valid : m_rsp[m].r_valid;
        end
        if (!hit) begin
            $display("timeout: master %0d got no response", m);
            err_count++;
        end
        // valid must not drop while ready is low
        for (int d = 0; d < dly && hit; d++) begin
            @(negedge clk);
            if (!(wr ? m_rsp[m].b_valid : m_rsp[m].r_valid)) begin
                $display("response of master %0d dropped before ready", m);
                err_count++;
            end
        end
        @(posedge clk);
        #1;
        if (hit) begin
            m_req[m].b_ready = wr;
            m_req[m].r_ready = !wr;
            @(negedge clk);
            resp  = wr ? m_rsp[m].b_resp : m_rsp[m].r_resp;
            rdata = m_rsp[m].r_data;
            @(posedge clk);
            #1;
            m_req[m].b_ready = 1'b0;
            m_req[m].r_ready = 1'b0;
        end
    endtask

    // one whole transaction, entered and left 1 ns after a rising edge
    task automatic axi_txn(input int m, input bit wr, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] strb, input int dly,
                           output logic [1:0] resp, output logic [31:0] rdata);
        int n;
        bit hit;
        resp  = 2'bxx;
        rdata = 'x;
        hit   = 1'b0;
        if (wr) begin
            m_req[m].aw_valid = 1'b1;
            m_req[m].aw_addr  = addr;
            m_req[m].w_valid  = 1'b1;
            m_req[m].w_data   = data;
            m_req[m].w_strb   = strb;
        end else begin
            m_req[m].ar_valid = 1'b1;
            m_req[m].ar_addr  = addr;
        end
        for (n = 0; n < TIMEOUT && !hit; n++) begin
            @(negedge clk);
            hit = wr ? m_rsp[m].aw_ready : m_rsp[m].ar_ready;
            // address and data of a write are taken together
            if (wr && (m_rsp[m].w_ready !== m_rsp[m].aw_ready)) begin
                $display("master %0d raised aw_ready and w_ready apart", m);
                err_count++;
            end
        end
        @(posedge clk);
        #1;
        m_req[m].aw_valid = 1'b0;
        m_req[m].w_valid  = 1'b0;
        m_req[m].ar_valid = 1'b0;
        if (!hit) begin
            $display("timeout: master %0d request was never accepted", m);
            err_count++;
        end else begin
            take_rsp(m, wr, dly, resp, rdata);
        end
    endtask

    // master 0 reads every word of every bank against the model
    task automatic check_all_banks(input string name);
        logic [1:0]  resp;
        logic [31:0] rdata;
        for (int b = 0; b < `NO_SLAVES; b++) begin
            for (int r = 0; r < `REGS_PER_SLAVE; r++) begin
                axi_txn(0, 1'b0, make_addr(b, r), '0, '0, 0, resp, rdata);
                check_equal({name, " resp"}, 32'(OKAY), 32'(resp));
                check_equal($sformatf("%0s bank %0d reg %0d", name, b, r),
                            model[b][r], rdata);
            end
        end
    endtask

    // words m, m+3, ... belong to master m only
    task automatic run_traffic(input int m, input int count);
        int          bank;
        int          reg_i;
        int          dly;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [1:0]  resp;
        logic [31:0] rdata;
        for (int k = 0; k < count; k++) begin
            bank  = int'(rand_bits(3) % 32'd5);
            reg_i = m + 3 * int'(rand_bits(3) % 32'd5);
            dly   = int'(rand_bits(2));
            if (rand_bits(1) == 32'd1) begin
                data = rand_bits(32);
                strb = 4'(rand_bits(4));
                axi_txn(m, 1'b1, make_addr(bank, reg_i), data, strb, dly, resp, rdata);
                check_equal("traffic write resp", 32'(OKAY), 32'(resp));
                model[bank][reg_i] = merge(model[bank][reg_i], data, strb);
            end else begin
                axi_txn(m, 1'b0, make_addr(bank, reg_i), '0, '0, dly, resp, rdata);
                check_equal("traffic read resp", 32'(OKAY), 32'(resp));
                check_equal($sformatf("traffic m%0d bank %0d reg %0d", m, bank, reg_i),
                            model[bank][reg_i], rdata);
            end
        end
    endtask

    // full-word writes to reg 15, b_ready always high, order of b_valid recorded
    task automatic run_race(input string name, input int first, input int second,
                            input int third);
        bit          taken [`NO_MASTERS];
        bit          finished [`NO_MASTERS];
        logic [31:0] wdata [`NO_MASTERS];
        int          exp_order [`NO_MASTERS];
        int          left;
        int          n_exp;
        exp_order = '{first, second, third};
        left      = 0;
        n_exp     = 0;
        order_q.delete();
        for (int m = 0; m < `NO_MASTERS; m++) begin
            taken[m]         = 1'b0;
            finished[m]      = (race_start[m] < 0);
            wdata[m]         = rand_bits(32);
            m_req[m].b_ready = 1'b1;
            if (race_start[m] >= 0) left++;
            if (exp_order[m] >= 0) n_exp++;
        end
        for (int cyc = 0; cyc < TIMEOUT && left > 0; cyc++) begin
            for (int m = 0; m < `NO_MASTERS; m++) begin
                if (cyc == race_start[m]) begin
                    m_req[m].aw_valid = 1'b1;
                    m_req[m].aw_addr  = make_addr(race_bank[m], 15);
                    m_req[m].w_valid  = 1'b1;
                    m_req[m].w_data   = wdata[m];
                    m_req[m].w_strb   = 4'hf;
                end
            end
            @(negedge clk);
            for (int m = 0; m < `NO_MASTERS; m++) begin
                if (m_rsp[m].aw_ready) taken[m] = 1'b1;
                if (m_rsp[m].b_valid && !finished[m]) begin
                    finished[m] = 1'b1;
                    left--;
                    order_q.push_back(m);
                    check_equal({name, " resp"}, 32'(OKAY), 32'(m_rsp[m].b_resp));
                    model[race_bank[m]][15] = wdata[m];
                end
            end
            @(posedge clk);
            #1;
            for (int m = 0; m < `NO_MASTERS; m++) begin
                if (taken[m]) begin
                    m_req[m].aw_valid = 1'b0;
                    m_req[m].w_valid  = 1'b0;
                end
            end
        end
        for (int m = 0; m < `NO_MASTERS; m++) m_req[m].b_ready = 1'b0;
        if (left > 0) begin
            $display("timeout: %0s still had %0d writes open", name, left);
            err_count++;
        end
        if (order_q.size() != n_exp) begin
            $display("%0s: %0d of %0d write responses arrived", name, order_q.size(), n_exp);
            err_count++;
        end else begin
            for (int i = 0; i < n_exp; i++) begin
                check_equal($sformatf("%0s position %0d", name, i),
                            32'(exp_order[i]), 32'(order_q[i]));
            end
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_count == test_errs) begin
            $display("test %0s: ok", name);
        end else begin
            tests_failed++;
            $display("test %0s: %0d errors", name, err_count - test_errs);
        end
        test_errs = err_count;
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] rdata;
        logic [3:0]  strb;
        logic [1:0]  resp;
        int          reg_i;
        clk    = 1'b0;
        arst_n = 1'b0;
        for (int m = 0; m < `NO_MASTERS; m++) m_req[m] = '0;
        for (int b = 0; b < `NO_SLAVES; b++) begin
            for (int r = 0; r < `REGS_PER_SLAVE; r++) model[b][r] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        idle_cycles(2);

        // random words and strobes into every bank from master 0
        for (int b = 0; b < `NO_SLAVES; b++) begin
            for (int k = 0; k < 4; k++) begin
                reg_i = int'(rand_bits(4));
                data  = rand_bits(32);
                strb  = 4'(rand_bits(4));
                axi_txn(0, 1'b1, make_addr(b, reg_i), data, strb, 0, resp, rdata);
                check_equal("single write resp", 32'(OKAY), 32'(resp));
                model[b][reg_i] = merge(model[b][reg_i], data, strb);
            end
        end
        check_all_banks("single readback");
        end_test("single_write_read");

        // regions 5 to 7, then a mapped region with an upper bit set
        for (int k = 0; k < 6; k++) begin
            addr = (k < 3) ? make_addr(5 + k, k) : (make_addr(k - 3, k) | (32'h800 << k));
            axi_txn(k % 3, 1'b1, addr, rand_bits(32), 4'hf, 0, resp, rdata);
            check_equal("decerr write resp", 32'(DECERR), 32'(resp));
            axi_txn(k % 3, 1'b0, addr, '0, '0, 0, resp, rdata);
            check_equal("decerr read resp", 32'(DECERR), 32'(resp));
            check_equal("decerr read data", 32'h0, rdata);
        end
        check_all_banks("decerr readback");
        end_test("decode_error");

        fork
            run_traffic(0, 20);
            run_traffic(1, 20);
            run_traffic(2, 20);
        join
        check_all_banks("traffic readback");
        end_test("random_traffic");

        // a few quiet cycles clear the spread flag
        idle_cycles(4);
        race_bank  = '{0, 1, 2};
        race_start = '{0, 0, 0};
        run_race("idle_pick", 0, 1, 2);
        end_test("idle_pick_order");

        // spread passes master 1 over for master 2, whose grant cycle
        // then sees master 1 still waiting and hands the bus back to it
        idle_cycles(4);
        race_bank  = '{0, 0, 1};
        race_start = '{0, 0, 0};
        run_race("spread", 0, 1, 2);
        end_test("spread_order");

        // master 2 one cycle ahead, master 0 lands in its grant cycle
        idle_cycles(4);
        race_bank  = '{4, 0, 2};
        race_start = '{1, -1, 0};
        run_race("preempt", 0, 2, -1);
        check_all_banks("race readback");
        end_test("preemption");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+hw
hw/axi_lite_pkg.sv
hw/fabric_pkg.sv
hw/master_port.sv
hw/priority_selector.sv
hw/bus_arbiter.sv
hw/slave_bank.sv
hw/bus_fabric_top.sv
sim/fabric_checker.sv
sim/tb_bus_fabric.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the fabric testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module tb_bus_fabric -f build.f || exit 1
out="$(./obj_dir/Vtb_bus_fabric 2>&1)"
echo "$out"
echo "$out" | grep -qx "RESULT: PASS" && exit 0 || exit 1
